// ==== files.f ====
common/ledm_pkg.sv
common/ledm_cfg_if.sv
ledm/ledm_csr.sv
ledm/ledm_scan.sv
hdl/ledm_top.sv
bench/ledm_tb.sv

// ==== Makefile ====
# Verilator build and run for the LED matrix controller testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := ledm_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Run, keep the log, and decide the verdict from it
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/ledm_tb.sv ====
// Directed testbench for ledm_top, CSR map checks plus scan order and PWM widths.
// Phase starts are found from row_lvl/row_oe changes, which every phase has.
`timescale 1ns/1ps

module ledm_tb;
	import ledm_pkg::*;

	// ========================================================================
	// Constants, DUT and monitor
	// ========================================================================

	localparam int PHASE_STEPS = 1 << PWM_BITS;
	// Clock / steps / two directions / rows / refresh rate
	localparam pre_t EXP_PRE_RESET =
		pre_t'(CLK_FREQ / PHASE_STEPS / 2 / LED_ROWS / REFRESH_HZ);
	// CSR traffic, about 14 phases at prescaler 0 and 4 at prescaler 2, then doubled
	localparam int MAX_CYCLES = 2 * (800 + 14 * PHASE_STEPS + 4 * 3 * PHASE_STEPS);
	localparam logic [13:0] IDLE_ADDR = 14'h0000;
	localparam logic [13:0] PRE_ADDR  = {CSR_PAGE, 2'b01, 8'h00};

	logic                sys_clk;
	logic                sys_rst;
	logic [13:0]         csr_a;
	logic                csr_we;
	logic [31:0]         csr_di;
	logic [31:0]         csr_do;
	logic [LED_ROWS-1:0] row_lvl;
	logic [LED_ROWS-1:0] row_oe;
	logic [LED_COLS-1:0] col_lvl;
	logic [LED_COLS-1:0] col_oe;

	int                  cyc;
	int                  errors;
	int                  checks;
	int                  phase_num;
	int                  phase_len;
	int                  on_cnt [LED_COLS];
	logic [31:0]         rng = 32'hac28_b61f;
	logic                phase_edge;
	logic [LED_ROWS-1:0] prev_row_lvl = '0;
	logic [LED_ROWS-1:0] prev_row_oe = '0;
	// Model of the duty array, [row][direction][column]
	duty_t               exp_duty [LED_ROWS][2][LED_COLS];

	ledm_top ledm_top_i (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.csr_a   (csr_a),
		.csr_we  (csr_we),
		.csr_di  (csr_di),
		.csr_do  (csr_do),
		.row_lvl (row_lvl),
		.row_oe  (row_oe),
		.col_lvl (col_lvl),
		.col_oe  (col_oe)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// Direction flips on every phase start, the very first start also raises row_oe
	assign phase_edge = (row_lvl != prev_row_lvl) || (row_oe != prev_row_oe);

	// Phase index counts starts since reset, so it gives the row and direction
	always @(posedge sys_clk) begin
		cyc          <= cyc + 1;
		prev_row_lvl <= row_lvl;
		prev_row_oe  <= row_oe;
		if (sys_rst) begin
			phase_num <= 0;
		end else if (phase_edge) begin
			phase_num <= phase_num + 1;
		end
	end

	always @(negedge sys_clk) begin
		if (cyc > MAX_CYCLES) begin
			$display("Timeout, no verdict after %0d cycles", cyc);
			$display("Simulation failed");
			$finish;
		end
	end

	// ========================================================================
	// Helpers and compare tasks
	// ========================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Page, bit 8 clear, row in 4:3, column in 2:1, direction in 0
	function automatic logic [13:0] led_addr(input int r, input int d, input int c);
		return {CSR_PAGE, 5'b00000, 2'(r), 2'(c), 1'(d)};
	endfunction

	task automatic check_duty(input string name, input duty_t exp, input duty_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_pre(input string name, input pre_t exp, input pre_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERR %0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
		end
	endtask

	// Row or column vector, zero-extended to 8 bits
	task automatic check_lines(input string name, input logic [7:0] exp,
			input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic csr_write(input logic [13:0] addr, input logic [31:0] data);
		@(posedge sys_clk);
		csr_a  <= addr;
		csr_we <= 1'b1;
		csr_di <= data;
		@(posedge sys_clk);
		csr_a  <= IDLE_ADDR;
		csr_we <= 1'b0;
	endtask

	// Registered read data, taken in the cycle after the address
	task automatic csr_read(input logic [13:0] addr, output logic [31:0] data);
		@(posedge sys_clk);
		csr_a  <= addr;
		csr_we <= 1'b0;
		@(posedge sys_clk);
		csr_a <= IDLE_ADDR;
		@(negedge sys_clk);
		data = csr_do;
	endtask

	task automatic verify_duties();
		logic [31:0] rd;
		for (int r = 0; r < LED_ROWS; r++) begin
			for (int d = 0; d < 2; d++) begin
				for (int c = 0; c < LED_COLS; c++) begin
					csr_read(led_addr(r, d, c), rd);
					check_word($sformatf("csr_do duty r%0d d%0d c%0d", r, d, c),
						32'(exp_duty[r][d][c]), rd);
				end
			end
		end
	endtask

	// Returns on the first cycle of the next phase
	task automatic wait_phase();
		@(negedge sys_clk);
		while (!phase_edge) begin
			@(negedge sys_clk);
		end
	endtask

	// The first start after the write can still carry an old step length
	task automatic set_prescaler(input pre_t p);
		csr_write(PRE_ADDR, 32'(p));
		wait_phase();
		wait_phase();
	endtask

	task automatic check_phase_start();
		int r;
		int d;
		r = (phase_num / 2) % LED_ROWS;
		d = phase_num % 2;
		check_lines("row_oe", 8'(1 << r), 8'(row_oe));
		check_lines("row_lvl", (d != 0) ? 8'((1 << LED_ROWS) - 1) : 8'h00, 8'(row_lvl));
		check_lines("col_lvl", (d != 0) ? 8'h00 : 8'((1 << LED_COLS) - 1), 8'(col_lvl));
	endtask

	// High cycles per column, from this phase start up to the next one
	task automatic measure_phase();
		phase_len = 0;
		foreach (on_cnt[c]) begin
			on_cnt[c] = 0;
		end
		while (phase_len == 0 || !phase_edge) begin
			for (int c = 0; c < LED_COLS; c++) begin
				if (col_oe[c]) begin
					on_cnt[c]++;
				end
			end
			phase_len++;
			@(negedge sys_clk);
		end
	endtask

	// Each column on for duty x (prescaler+1) cycles
	task automatic check_phase_widths(input pre_t p);
		int r;
		int d;
		r = (phase_num / 2) % LED_ROWS;
		d = phase_num % 2;
		measure_phase();
		check_word("phase length", 32'(PHASE_STEPS * (int'(p) + 1)), 32'(phase_len));
		for (int c = 0; c < LED_COLS; c++) begin
			check_word($sformatf("col_oe[%0d] high cycles", c),
				32'(int'(exp_duty[r][d][c]) * (int'(p) + 1)), 32'(on_cnt[c]));
		end
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================

	task automatic test_reset();
		logic [31:0] rd;
		repeat (15) @(posedge sys_clk);
		@(negedge sys_clk);
		check_lines("row_oe", 8'h00, 8'(row_oe));
		check_lines("col_oe", 8'h00, 8'(col_oe));
		check_word("csr_do", 32'h0, csr_do);
		@(posedge sys_clk);
		sys_rst <= 1'b0;
		// Row 0 direction 0 starts at once, all dark
		@(posedge sys_clk);
		@(negedge sys_clk);
		check_lines("row_oe", 8'h01, 8'(row_oe));
		check_lines("col_oe", 8'h00, 8'(col_oe));
		csr_read(PRE_ADDR, rd);
		check_pre("csr_do prescaler", EXP_PRE_RESET, pre_t'(rd));
		for (int r = 0; r < LED_ROWS; r++) begin
			for (int d = 0; d < 2; d++) begin
				for (int c = 0; c < LED_COLS; c++) begin
					csr_read(led_addr(r, d, c), rd);
					check_duty($sformatf("csr_do duty r%0d d%0d c%0d", r, d, c),
						'0, duty_t'(rd));
				end
			end
		end
	endtask

	task automatic test_csr_map();
		logic [31:0] rd;
		logic [13:0] bad_addr;
		pre_t        pre_val;
		for (int r = 0; r < LED_ROWS; r++) begin
			for (int d = 0; d < 2; d++) begin
				for (int c = 0; c < LED_COLS; c++) begin
					rng = xorshift32(rng);
					exp_duty[r][d][c] = duty_t'(rng);
					csr_write(led_addr(r, d, c), rng);
				end
			end
		end
		verify_duties();
		rng = xorshift32(rng);
		pre_val = pre_t'(rng);
		csr_write(PRE_ADDR, rng);
		csr_read(PRE_ADDR, rd);
		check_pre("csr_do prescaler", pre_val, pre_t'(rd));
		// Neighbouring page, then the first row past the array
		bad_addr = led_addr(0, 1, 2);
		bad_addr[13:10] = CSR_PAGE ^ 4'h1;
		csr_write(bad_addr, ~32'(exp_duty[0][1][2]));
		csr_read(bad_addr, rd);
		check_word("csr_do wrong page", 32'h0, rd);
		csr_write(led_addr(LED_ROWS, 0, 1), 32'h0000_00a5);
		csr_read(led_addr(LED_ROWS, 0, 1), rd);
		check_word("csr_do row out of range", 32'h0, rd);
		verify_duties();
	endtask

	task automatic test_phase_order();
		set_prescaler(8'd0);
		// One more than a full cycle of rows, so the wrap is seen
		for (int i = 0; i < 2 * LED_ROWS + 1; i++) begin
			check_phase_start();
			measure_phase();
			check_word("phase length", 32'(PHASE_STEPS), 32'(phase_len));
		end
	endtask

	task automatic test_pwm_width();
		repeat (2) check_phase_widths(8'd0);
		set_prescaler(8'd2);
		repeat (2) check_phase_widths(8'd2);
	endtask

	task automatic test_dark_and_full();
		// Column 0 dark, column 1 full, the rest random
		for (int r = 0; r < LED_ROWS; r++) begin
			for (int d = 0; d < 2; d++) begin
				for (int c = 0; c < LED_COLS; c++) begin
					rng = xorshift32(rng);
					if (c == 0) begin
						exp_duty[r][d][c] = '0;
					end else if (c == 1) begin
						exp_duty[r][d][c] = '1;
					end else begin
						exp_duty[r][d][c] = duty_t'(rng);
					end
					csr_write(led_addr(r, d, c), 32'(exp_duty[r][d][c]));
				end
			end
		end
		set_prescaler(8'd0);
		repeat (2) begin
			// Row and column levels from the phase index, opposite in each phase
			check_phase_start();
			check_phase_widths(8'd0);
		end
	endtask

	initial begin
		sys_rst = 1'b1;
		csr_a   = IDLE_ADDR;
		csr_we  = 1'b0;
		csr_di  = '0;
		test_reset();
		test_csr_map();
		test_phase_order();
		test_pwm_width();
		test_dark_and_full();
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== hdl/ledm_top.sv ====
// LED matrix controller top, CSR port plus per-line level and output enable.
// Tri-state pads are built outside from *_lvl and *_oe.
`timescale 1ns/1ps

module ledm_top (
	input  logic                          sys_clk,
	input  logic                          sys_rst,

	// CSR port, plain strobes
	input  logic [13:0]                   csr_a,
	input  logic                          csr_we,
	input  logic [31:0]                   csr_di,
	output logic [31:0]                   csr_do,

	// Matrix lines
	output logic [ledm_pkg::LED_ROWS-1:0] row_lvl,
	output logic [ledm_pkg::LED_ROWS-1:0] row_oe,
	output logic [ledm_pkg::LED_COLS-1:0] col_lvl,
	output logic [ledm_pkg::LED_COLS-1:0] col_oe
);

	// ========================================================================
	// Register file to scan engine link
	// ========================================================================

	ledm_cfg_if cfg_if ();

	// Duty array, prescaler and CSR read path
	ledm_csr ledm_csr_i (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.csr_a   (csr_a),
		.csr_we  (csr_we),
		.csr_di  (csr_di),
		.csr_do  (csr_do),
		.cfg     (cfg_if.regs)
	);

	// Phase sequencing and PWM turn-off
	ledm_scan ledm_scan_i (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.cfg     (cfg_if.scan),
		.row_lvl (row_lvl),
		.row_oe  (row_oe),
		.col_lvl (col_lvl),
		.col_oe  (col_oe)
	);

endmodule

// ==== ledm/ledm_scan.sv ====
// Row/direction scan with per-column PWM turn-off; outputs are level plus enable per line.
// The board wrapper turns oe=0 into Z; a prescaler change applies from the next step reload.
`timescale 1ns/1ps

module ledm_scan (
	input  logic                          sys_clk,
	input  logic                          sys_rst,
	ledm_cfg_if.scan                      cfg,
	output logic [ledm_pkg::LED_ROWS-1:0] row_lvl,
	output logic [ledm_pkg::LED_ROWS-1:0] row_oe,
	output logic [ledm_pkg::LED_COLS-1:0] col_lvl,
	output logic [ledm_pkg::LED_COLS-1:0] col_oe
);
	import ledm_pkg::*;

	// ========================================================================
	// Counters
	// ========================================================================

	// Step divider, counts down from the prescaler
	pre_t pre_cnt;

	// PWM position inside the phase, 0 starts a new phase
	duty_t pwm_cnt;

	// Row and direction of the next phase to start
	logic [ROW_BITS-1:0] nxt_row;
	logic                nxt_dir;

	// Row and direction of the phase being shown
	logic [ROW_BITS-1:0] cur_row;
	logic                cur_dir;

	logic step;
	logic phase_start;

	// One PWM step every prescaler+1 cycles
	assign step        = (pre_cnt == '0);
	assign phase_start = step && (pwm_cnt == '0);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pre_cnt <= '0;
			pwm_cnt <= '0;
		end else if (step) begin
			// Reload picks up any new prescaler value here
			pre_cnt <= cfg.prescaler;
			pwm_cnt <= pwm_cnt + 1'b1;
		end else begin
			pre_cnt <= pre_cnt - 1'b1;
		end
	end

	// ========================================================================
	// Duty lookup
	// ========================================================================

	// During step 0 look ahead to the next phase, otherwise the current one
	assign cfg.rd_row = (pwm_cnt == '0) ? nxt_row : cur_row;
	assign cfg.rd_dir = (pwm_cnt == '0) ? nxt_dir : cur_dir;

	// ========================================================================
	// Row and direction sequencer
	// ========================================================================

	// Order is r0 d0, r0 d1, r1 d0, ... then back to r0
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			nxt_row <= '0;
			nxt_dir <= 1'b0;
			cur_row <= '0;
			cur_dir <= 1'b0;
		end else if (phase_start) begin
			cur_row <= nxt_row;
			cur_dir <= nxt_dir;
			nxt_dir <= ~nxt_dir;
			// Row moves on only after both directions were shown
			if (nxt_dir) begin
				if (nxt_row == ROW_BITS'(LED_ROWS - 1)) begin
					nxt_row <= '0;
				end else begin
					nxt_row <= nxt_row + 1'b1;
				end
			end
		end
	end

	// ========================================================================
	// Line drivers
	// ========================================================================

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			row_oe  <= '0;
			row_lvl <= '0;
			col_oe  <= '0;
			col_lvl <= '0;
		end else if (phase_start) begin
			// Direction 0: row low, columns high; direction 1 the other way
			for (int r = 0; r < LED_ROWS; r++) begin
				row_oe[r] <= (nxt_row == ROW_BITS'(r));
			end
			row_lvl <= {LED_ROWS{nxt_dir}};
			col_lvl <= {LED_COLS{~nxt_dir}};
			// Duty 0 stays dark for the whole phase
			for (int c = 0; c < LED_COLS; c++) begin
				col_oe[c] <= (cfg.duty_row[c] != '0);
			end
		end else if (step) begin
			// Turn off each column once its duty is reached
			for (int c = 0; c < LED_COLS; c++) begin
				if (cfg.duty_row[c] == pwm_cnt) begin
					col_oe[c] <= 1'b0;
				end
			end
		end
	end

	// ========================================================================
	// Checks
	// ========================================================================

	// Never two rows driven at once
	a_row_onehot: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		$onehot0(row_oe)
	);

	// Columns only switch on at a phase boundary
	a_col_no_reenable: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		((col_oe & ~$past(col_oe)) != '0) |-> $past(phase_start)
	);

	// Prescaler only moves together with its write strobe
	a_pre_wr_strobe: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		(cfg.prescaler != $past(cfg.prescaler)) |-> cfg.pre_wr
	);

endmodule

// ==== ledm/ledm_csr.sv ====
// Register file for per-LED duty words and the shared prescaler.
// No handshake: any cycle with a selected address is an access, read data lags by one cycle.
`timescale 1ns/1ps

module ledm_csr (
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  logic [13:0] csr_a,
	input  logic        csr_we,
	input  logic [31:0] csr_di,
	output logic [31:0] csr_do,
	ledm_cfg_if.regs    cfg
);
	import ledm_pkg::*;

	// ========================================================================
	// Address decode
	// ========================================================================

	ledm_addr_u addr;
	logic       page_hit;
	logic       led_hit;
	logic       pre_hit;

	assign addr     = csr_a[9:0];
	assign page_hit = (csr_a[13:10] == CSR_PAGE);

	// Duty access only for a row and column that exist
	assign led_hit = page_hit && !addr.led.sel
		&& (int'(addr.led.row) < LED_ROWS)
		&& (int'(addr.led.col) < LED_COLS);

	// Prescaler is a single register, low bits don't matter
	assign pre_hit = page_hit && addr.pre.sel;

	// ========================================================================
	// Storage
	// ========================================================================

	// Indexed [row][direction][column]
	duty_t duty_mem [LED_ROWS][2][LED_COLS];
	pre_t  pre_q;
	logic  pre_wr_q;

	// Duty array, all dark after reset
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			for (int r = 0; r < LED_ROWS; r++) begin
				for (int d = 0; d < 2; d++) begin
					for (int c = 0; c < LED_COLS; c++) begin
						duty_mem[r][d][c] <= '0;
					end
				end
			end
		end else if (led_hit && csr_we) begin
			duty_mem[addr.led.row][addr.led.dir][addr.led.col] <= csr_di[PWM_BITS-1:0];
		end
	end

	// Prescaler and its write strobe
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pre_q    <= PRE_RESET;
			pre_wr_q <= 1'b0;
		end else begin
			// Pulse lines up with the cycle the new value is visible
			pre_wr_q <= pre_hit && csr_we;
			if (pre_hit && csr_we) begin
				pre_q <= csr_di[PRE_BITS-1:0];
			end
		end
	end

	// ========================================================================
	// Read data
	// ========================================================================

	// Old value on read-and-write, zero for anything not decoded
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else if (led_hit) begin
			csr_do <= 32'(duty_mem[addr.led.row][addr.led.dir][addr.led.col]);
		end else if (pre_hit) begin
			csr_do <= 32'(pre_q);
		end else begin
			csr_do <= '0;
		end
	end

	// ========================================================================
	// Scan engine side
	// ========================================================================

	// Combinational so the engine sees the new row on its phase-start edge
	always_comb begin
		for (int c = 0; c < LED_COLS; c++) begin
			cfg.duty_row[c] = duty_mem[cfg.rd_row][cfg.rd_dir][c];
		end
	end

	assign cfg.prescaler = pre_q;
	assign cfg.pre_wr    = pre_wr_q;

	// Scan engine must never look up a row past the array
	a_rd_row_range: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		int'(cfg.rd_row) < LED_ROWS
	);

endmodule

// ==== common/ledm_cfg_if.sv ====
// Link from the register file to the scan engine.
// duty_row is a combinational lookup of the row and direction on rd_row/rd_dir.
`timescale 1ns/1ps

interface ledm_cfg_if;
	import ledm_pkg::*;

	// Row and direction the scan engine wants duties for
	logic [ROW_BITS-1:0] rd_row;
	logic                rd_dir;

	// Duty words of that row and direction, one per column
	duty_t [LED_COLS-1:0] duty_row;

	// Current step divider setting
	pre_t prescaler;

	// One cycle after a prescaler write, aligned with the new value
	logic pre_wr;

	modport regs (
		output duty_row,
		output prescaler,
		output pre_wr,
		input  rd_row,
		input  rd_dir
	);

	modport scan (
		input  duty_row,
		input  prescaler,
		input  pre_wr,
		output rd_row,
		output rd_dir
	);

endinterface

// ==== common/ledm_pkg.sv ====
// Shared sizes, CSR address layout and reset values for the LED matrix controller.
// Matrix size is fixed here; ROW_BITS/COL_BITS must cover LED_ROWS/LED_COLS.
package ledm_pkg;

	// ========================================================================
	// Matrix geometry
	// ========================================================================

	// Rows and columns of antiparallel LED pairs
	localparam int LED_ROWS = 3;
	localparam int LED_COLS = 4;

	// Index widths for the address fields
	localparam int ROW_BITS = 2;
	localparam int COL_BITS = 2;

	// ========================================================================
	// PWM and prescaler
	// ========================================================================

	// Duty word and PWM counter width, one phase is 2**PWM_BITS steps
	localparam int PWM_BITS = 8;

	// Step divider width
	localparam int PRE_BITS = 8;

	// Value of csr_a[13:10] that selects this block
	localparam logic [3:0] CSR_PAGE = 4'h9;

	// Clock and target refresh rate for the whole matrix
	localparam int CLK_FREQ   = 100_000_000;
	localparam int REFRESH_HZ = 1_000;

	typedef logic [PWM_BITS-1:0] duty_t;
	typedef logic [PRE_BITS-1:0] pre_t;

	// Clock / PWM steps / two directions / rows / refresh
	// 100 MHz / 256 / 2 / 3 / 1 kHz gives 65
	localparam pre_t PRE_RESET =
		pre_t'(((CLK_FREQ >> PWM_BITS) / 2) / LED_ROWS / REFRESH_HZ);

	// ========================================================================
	// CSR address layout, low 10 bits
	// ========================================================================

	// Bit 8 clear: one LED duty word
	//   9 8 7 6 5 4 3 2 1 0
	//   x 0 x x x R R C C D
	typedef struct packed {
		logic                rsvd_hi;
		logic                sel;
		logic [2:0]          rsvd;
		logic [ROW_BITS-1:0] row;
		logic [COL_BITS-1:0] col;
		logic                dir;
	} ledm_led_addr_t;

	// Bit 8 set: the shared prescaler, low bits ignored
	typedef struct packed {
		logic       rsvd_hi;
		logic       sel;
		logic [7:0] rsvd;
	} ledm_pre_addr_t;

	// Same address word, two decodes chosen by bit 8
	typedef union packed {
		ledm_led_addr_t led;
		ledm_pre_addr_t pre;
	} ledm_addr_u;

endpackage
